/* Makefile */
VERILATOR ?= verilator
TOP ?= yuv_to_rgb_tb
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Test passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* design/chroma_window.sv */
`timescale 1ns/10ps

module chroma_window import yuv_pkg::*; (
	input logic CLOCK_50_I,
	input logic resetn,
	input logic in_valid,
	input sample_t in_y_even,
	input sample_t in_y_odd,
	input sample_t in_u,
	input sample_t in_v,
	output logic busy,
	chroma_window_if.source win
);

	logic [$clog2(LINE_PAIRS)-1:0] pair_cnt;
	logic flushing;
	logic [1:0] flush_cnt;
	logic flush_go;
	logic shift_en;

	tap_window_t u_sr;
	tap_window_t v_sr;
	sample_t y_even_d [0:2];
	sample_t y_odd_d [0:2];
	sample_t y_even_q;
	sample_t y_odd_q;
	logic last_q;

	// Flush steps wait until execute has taken the previous window
	assign flush_go = flushing && !in_valid && !win.win_valid && !win.running;
	assign shift_en = in_valid || flush_go;
	assign busy = win.win_valid || win.running || flushing;

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			pair_cnt <= '0;
			flushing <= 1'b0;
			flush_cnt <= '0;
			win.win_valid <= 1'b0;
		end else begin
			win.win_valid <= 1'b0;
			if (in_valid) begin
				// Pairs 0 to 2 only fill the window
				if (pair_cnt >= 3)
					win.win_valid <= 1'b1;
				if (pair_cnt == LINE_PAIRS - 1) begin
					pair_cnt <= '0;
					flushing <= 1'b1;
				end else begin
					pair_cnt <= pair_cnt + 1'b1;
				end
			end else if (flush_go) begin
				win.win_valid <= 1'b1;
				flush_cnt <= flush_cnt + 1'b1;
				if (flush_cnt == 2'd2) begin
					flushing <= 1'b0;
					flush_cnt <= '0;
				end
			end
		end
	end

	always_ff @(posedge CLOCK_50_I) begin
		if (shift_en) begin
			for (int i = 0; i < 5; i++) begin
				u_sr[i] <= u_sr[i+1];
				v_sr[i] <= v_sr[i+1];
			end
			// During the flush the last sample of the line repeats
			u_sr[5] <= in_valid ? in_u : u_sr[5];
			v_sr[5] <= in_valid ? in_v : v_sr[5];
			// First sample of a line stands in for everything before it
			if (in_valid && pair_cnt == 0) begin
				u_sr <= {6{in_u}};
				v_sr <= {6{in_v}};
			end

			// Luma lags three pairs behind the newest chroma
			y_even_q <= y_even_d[0];
			y_odd_q <= y_odd_d[0];
			for (int i = 0; i < 2; i++) begin
				y_even_d[i] <= y_even_d[i+1];
				y_odd_d[i] <= y_odd_d[i+1];
			end
			y_even_d[2] <= in_y_even;
			y_odd_d[2] <= in_y_odd;

			last_q <= flush_go && flush_cnt == 2'd2;
		end
	end

	assign win.y_even = y_even_q;
	assign win.y_odd = y_odd_q;
	assign win.u_taps = u_sr;
	assign win.v_taps = v_sr;
	assign win.last_pair = last_q;

endmodule

/* design/chroma_window_if.sv */
`timescale 1ns/10ps

// One filter window and its luma pair, decode to execute
interface chroma_window_if import yuv_pkg::*; ();
	logic win_valid;
	sample_t y_even;
	sample_t y_odd;
	tap_window_t u_taps;
	tap_window_t v_taps;
	logic last_pair;
	// Back from execute, high while a pair is converting
	logic running;

	modport source (
		output win_valid, y_even, y_odd, u_taps, v_taps, last_pair,
		input running
	);
	modport sink (
		input win_valid, y_even, y_odd, u_taps, v_taps, last_pair,
		output running
	);
endinterface

/* design/csc_engine.sv */
`timescale 1ns/10ps

module csc_engine import yuv_pkg::*; (
	input logic CLOCK_50_I,
	input logic resetn,
	chroma_window_if.sink win,
	rgb_acc_if.source acc
);

	logic running;
	logic [$clog2(PAIR_CYCLES)-1:0] cnt;

	// Shared coefficient, one data operand per lane
	acc_t coef;
	acc_t data_even;
	acc_t data_odd;
	acc_t prod_even;
	acc_t prod_odd;

	acc_t u_acc;
	acc_t v_acc;
	acc_t r_acc_even;
	acc_t g_acc_even;
	acc_t b_acc_even;
	acc_t r_acc_odd;
	acc_t g_acc_odd;
	acc_t b_acc_odd;

	sample_t u_odd;
	sample_t v_odd;
	acc_t u_even_c;
	acc_t v_even_c;
	acc_t u_odd_c;
	acc_t v_odd_c;

	function automatic acc_t pair_sum(input sample_t a, input sample_t b);
		return acc_t'(a) + acc_t'(b);
	endfunction

	// Interpolated odd chroma, settled after the third cycle
	assign u_odd = clip_sample(u_acc, FILTER_SHIFT);
	assign v_odd = clip_sample(v_acc, FILTER_SHIFT);

	// Even pixel uses the centre tap as received
	assign u_even_c = acc_t'(win.u_taps[2]) - C_OFFSET;
	assign v_even_c = acc_t'(win.v_taps[2]) - C_OFFSET;
	assign u_odd_c = acc_t'(u_odd) - C_OFFSET;
	assign v_odd_c = acc_t'(v_odd) - C_OFFSET;

	assign prod_even = coef * data_even;
	assign prod_odd = coef * data_odd;

	// During the filter the even lane carries U and the odd lane V
	always_comb begin
		case (cnt)
			0: begin
				coef = TAP_INNER;
				data_even = pair_sum(win.u_taps[2], win.u_taps[3]);
				data_odd = pair_sum(win.v_taps[2], win.v_taps[3]);
			end
			1: begin
				coef = TAP_MIDDLE;
				data_even = pair_sum(win.u_taps[1], win.u_taps[4]);
				data_odd = pair_sum(win.v_taps[1], win.v_taps[4]);
			end
			2: begin
				coef = TAP_OUTER;
				data_even = pair_sum(win.u_taps[0], win.u_taps[5]);
				data_odd = pair_sum(win.v_taps[0], win.v_taps[5]);
			end
			3: begin
				coef = COEF_Y;
				data_even = acc_t'(win.y_even) - Y_OFFSET;
				data_odd = acc_t'(win.y_odd) - Y_OFFSET;
			end
			4: begin
				coef = COEF_RV;
				data_even = v_even_c;
				data_odd = v_odd_c;
			end
			5: begin
				coef = COEF_GU;
				data_even = u_even_c;
				data_odd = u_odd_c;
			end
			6: begin
				coef = COEF_GV;
				data_even = v_even_c;
				data_odd = v_odd_c;
			end
			default: begin
				coef = COEF_BU;
				data_even = u_even_c;
				data_odd = u_odd_c;
			end
		endcase
	end

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			running <= 1'b0;
			cnt <= '0;
		end else if (win.win_valid) begin
			running <= 1'b1;
			cnt <= '0;
		end else if (running) begin
			cnt <= cnt + 1'b1;
			if (cnt == PAIR_CYCLES - 1)
				running <= 1'b0;
		end
	end

	always_ff @(posedge CLOCK_50_I) begin
		if (running) begin
			case (cnt)
				0: begin
					u_acc <= FILTER_ROUND + prod_even;
					v_acc <= FILTER_ROUND + prod_odd;
				end
				1: begin
					u_acc <= u_acc - prod_even;
					v_acc <= v_acc - prod_odd;
				end
				2: begin
					u_acc <= u_acc + prod_even;
					v_acc <= v_acc + prod_odd;
				end
				3: begin
					r_acc_even <= prod_even;
					g_acc_even <= prod_even;
					b_acc_even <= prod_even;
					r_acc_odd <= prod_odd;
					g_acc_odd <= prod_odd;
					b_acc_odd <= prod_odd;
				end
				4: begin
					r_acc_even <= r_acc_even + prod_even;
					r_acc_odd <= r_acc_odd + prod_odd;
				end
				5, 6: begin
					g_acc_even <= g_acc_even + prod_even;
					g_acc_odd <= g_acc_odd + prod_odd;
				end
				default: ;
			endcase
		end
	end

	assign win.running = running;

	// Blue takes its last product straight from the multipliers
	assign acc.acc_valid = running && cnt == PAIR_CYCLES - 1;
	assign acc.r_even = r_acc_even;
	assign acc.g_even = g_acc_even;
	assign acc.b_even = b_acc_even + prod_even;
	assign acc.r_odd = r_acc_odd;
	assign acc.g_odd = g_acc_odd;
	assign acc.b_odd = b_acc_odd + prod_odd;
	assign acc.last_pair = win.last_pair;

endmodule

/* design/rgb_acc_if.sv */
`timescale 1ns/10ps

// Six colour accumulators of one pixel pair, execute to result
interface rgb_acc_if import yuv_pkg::*; ();
	logic acc_valid;
	acc_t r_even;
	acc_t g_even;
	acc_t b_even;
	acc_t r_odd;
	acc_t g_odd;
	acc_t b_odd;
	logic last_pair;

	modport source (output acc_valid, r_even, g_even, b_even, r_odd, g_odd, b_odd, last_pair);
	modport sink (input acc_valid, r_even, g_even, b_even, r_odd, g_odd, b_odd, last_pair);
endinterface

/* design/rgb_packer.sv */
`timescale 1ns/10ps

module rgb_packer import yuv_pkg::*; (
	input logic CLOCK_50_I,
	input logic resetn,
	rgb_acc_if.sink acc,
	output logic out_valid,
	output logic [WORD_W-1:0] out_word,
	output logic out_line_end
);

	logic [1:0] phase;
	sample_t r_even;
	sample_t g_even;
	sample_t b_even;
	sample_t r_odd;
	sample_t g_odd;
	sample_t b_odd;
	logic last_q;

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			out_valid <= 1'b0;
			phase <= '0;
		end else if (acc.acc_valid) begin
			out_valid <= 1'b1;
			phase <= '0;
		end else if (out_valid) begin
			phase <= phase + 1'b1;
			if (phase == 2'd2)
				out_valid <= 1'b0;
		end
	end

	// Scale and saturate once, on capture
	always_ff @(posedge CLOCK_50_I) begin
		if (acc.acc_valid) begin
			r_even <= clip_sample(acc.r_even, CSC_SHIFT);
			g_even <= clip_sample(acc.g_even, CSC_SHIFT);
			b_even <= clip_sample(acc.b_even, CSC_SHIFT);
			r_odd <= clip_sample(acc.r_odd, CSC_SHIFT);
			g_odd <= clip_sample(acc.g_odd, CSC_SHIFT);
			b_odd <= clip_sample(acc.b_odd, CSC_SHIFT);
			last_q <= acc.last_pair;
		end
	end

	always_comb begin
		case (phase)
			2'd0: out_word = {r_even, g_even};
			2'd1: out_word = {b_even, r_odd};
			default: out_word = {g_odd, b_odd};
		endcase
	end

	assign out_line_end = out_valid && phase == 2'd2 && last_q;

endmodule

/* design/yuv_pkg.sv */
package yuv_pkg;

	localparam int SAMPLE_W = 8;
	localparam int WORD_W = 16;
	localparam int ACC_W = 32;
	localparam int LINE_PAIRS = 160;

	// Chroma filter taps by distance from the centre
	localparam int TAP_OUTER = 21;
	localparam int TAP_MIDDLE = 52;
	localparam int TAP_INNER = 159;
	localparam int FILTER_ROUND = 128;
	localparam int FILTER_SHIFT = 8;

	localparam int Y_OFFSET = 16;
	localparam int C_OFFSET = 128;

	// Colour conversion, 16 fractional bits
	localparam int COEF_Y = 76284;
	localparam int COEF_RV = 104595;
	localparam int COEF_GU = -25624;
	localparam int COEF_GV = -53281;
	localparam int COEF_BU = 132251;
	localparam int CSC_SHIFT = 16;

	localparam int PAIR_CYCLES = 8;

	typedef logic [SAMPLE_W-1:0] sample_t;
	typedef logic signed [ACC_W-1:0] acc_t;
	// Index 0 holds the oldest sample
	typedef sample_t [0:5] tap_window_t;

	function automatic sample_t clip_sample(input acc_t value, input int unsigned shift);
		acc_t scaled;
		scaled = value >>> shift;
		if (scaled < 0)
			return '0;
		if (scaled > acc_t'(2 ** SAMPLE_W - 1))
			return '1;
		return scaled[SAMPLE_W-1:0];
	endfunction

endpackage

/* design/yuv_to_rgb.sv */
`timescale 1ns/10ps

module yuv_to_rgb import yuv_pkg::*; (
	input logic CLOCK_50_I,
	input logic resetn,
	input logic in_valid,
	input sample_t in_y_even,
	input sample_t in_y_odd,
	input sample_t in_u,
	input sample_t in_v,
	output logic busy,
	output logic out_valid,
	output logic [WORD_W-1:0] out_word,
	output logic out_line_end
);

	chroma_window_if win_if ();
	rgb_acc_if acc_if ();

	// Decode, execute and result stages
	chroma_window decode_i (
		.CLOCK_50_I(CLOCK_50_I),
		.resetn(resetn),
		.in_valid(in_valid),
		.in_y_even(in_y_even),
		.in_y_odd(in_y_odd),
		.in_u(in_u),
		.in_v(in_v),
		.busy(busy),
		.win(win_if.source)
	);

	csc_engine execute_i (
		.CLOCK_50_I(CLOCK_50_I),
		.resetn(resetn),
		.win(win_if.sink),
		.acc(acc_if.source)
	);

	rgb_packer result_i (
		.CLOCK_50_I(CLOCK_50_I),
		.resetn(resetn),
		.acc(acc_if.sink),
		.out_valid(out_valid),
		.out_word(out_word),
		.out_line_end(out_line_end)
	);

endmodule

/* src.f */
design/yuv_pkg.sv
design/chroma_window_if.sv
design/rgb_acc_if.sv
design/chroma_window.sv
design/csc_engine.sv
design/rgb_packer.sv
design/yuv_to_rgb.sv
tests/yuv_to_rgb_checker.sv
tests/yuv_to_rgb_tb.sv

/* tests/yuv_to_rgb_checker.sv */
`timescale 1ns/10ps

module yuv_to_rgb_checker import yuv_pkg::*; (
	input logic CLOCK_50_I,
	input logic resetn,
	input logic in_valid,
	input logic busy,
	input logic out_valid,
	input logic out_line_end,
	input logic acc_valid
);

	// Cycles since the last acc_valid, saturating
	logic [7:0] since_acc;

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn)
			since_acc <= '1;
		else if (acc_valid)
			since_acc <= '0;
		else if (since_acc != '1)
			since_acc <= since_acc + 1'b1;
	end

	no_strobe_while_busy: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		in_valid |-> !busy)
		else $error("in_valid pulsed while busy");

	// A pair leaves as three words, never four in a row
	out_run_max_three: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		out_valid && $past(out_valid) && $past(out_valid, 2) |-> !$past(out_valid, 3))
		else $error("out_valid held for more than three cycles");

	line_end_with_word: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		out_line_end |-> out_valid)
		else $error("out_line_end without out_valid");

	acc_spacing: assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
		acc_valid |-> since_acc >= PAIR_CYCLES - 1)
		else $error("acc_valid repeated too soon");

endmodule

bind yuv_to_rgb yuv_to_rgb_checker protocol_chk_i (
	.CLOCK_50_I(CLOCK_50_I),
	.resetn(resetn),
	.in_valid(in_valid),
	.busy(busy),
	.out_valid(out_valid),
	.out_line_end(out_line_end),
	.acc_valid(acc_if.acc_valid)
);

/* tests/yuv_to_rgb_tb.sv */
`timescale 1ns/10ps

module yuv_to_rgb_tb import yuv_pkg::*; ();

	localparam int NUM_LINES = 6;
	localparam int TIMEOUT_CYCLES = 2 * NUM_LINES * (LINE_PAIRS + 3) * (PAIR_CYCLES + 2);

	logic CLOCK_50_I;
	logic resetn;
	logic in_valid;
	sample_t in_y_even;
	sample_t in_y_odd;
	sample_t in_u;
	sample_t in_v;
	logic busy;
	logic out_valid;
	logic [WORD_W-1:0] out_word;
	logic out_line_end;

	// Samples of the line being sent
	sample_t line_y_even [0:LINE_PAIRS-1];
	sample_t line_y_odd [0:LINE_PAIRS-1];
	sample_t line_u [0:LINE_PAIRS-1];
	sample_t line_v [0:LINE_PAIRS-1];

	logic [WORD_W-1:0] exp_words [$];
	logic exp_ends [$];
	int cycle_count;
	logic [31:0] lfsr_state;

	yuv_to_rgb dut_i (
		.CLOCK_50_I(CLOCK_50_I),
		.resetn(resetn),
		.in_valid(in_valid),
		.in_y_even(in_y_even),
		.in_y_odd(in_y_odd),
		.in_u(in_u),
		.in_v(in_v),
		.busy(busy),
		.out_valid(out_valid),
		.out_word(out_word),
		.out_line_end(out_line_end)
	);

	always #2 CLOCK_50_I = ~CLOCK_50_I;

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("Test failed");
		$fatal(1, "Stopped at the first error");
	endtask

	always @(posedge CLOCK_50_I) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
			stop_on_error($sformatf("Timeout: run still going after %0d cycles", cycle_count));
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
	endfunction

	function automatic sample_t random_sample();
		sample_t s;
		s = '0;
		for (int i = 0; i < SAMPLE_W; i++) begin
			s = {s[SAMPLE_W-2:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return s;
	endfunction

	// Reference model
	function automatic sample_t saturate(input longint value, input int shift);
		longint s;
		s = value >>> shift;
		if (s < 0)
			return 8'h00;
		if (s > 255)
			return 8'hff;
		return s[7:0];
	endfunction

	// Beyond either end of the line the edge sample repeats
	function automatic longint chroma_at(input bit use_v, input int k);
		int idx;
		idx = (k < 0) ? 0 : ((k > LINE_PAIRS - 1) ? LINE_PAIRS - 1 : k);
		return use_v ? longint'(line_v[idx]) : longint'(line_u[idx]);
	endfunction

	function automatic sample_t odd_chroma(input bit use_v, input int j);
		longint sum;
		sum = FILTER_ROUND
			+ TAP_INNER * (chroma_at(use_v, j) + chroma_at(use_v, j + 1))
			- TAP_MIDDLE * (chroma_at(use_v, j - 1) + chroma_at(use_v, j + 2))
			+ TAP_OUTER * (chroma_at(use_v, j - 2) + chroma_at(use_v, j + 3));
		return saturate(sum, FILTER_SHIFT);
	endfunction

	function automatic logic [23:0] pixel_rgb(input sample_t y, input sample_t u, input sample_t v);
		longint luma;
		longint cu;
		longint cv;
		luma = COEF_Y * (longint'(y) - Y_OFFSET);
		cu = longint'(u) - C_OFFSET;
		cv = longint'(v) - C_OFFSET;
		return {saturate(luma + COEF_RV * cv, CSC_SHIFT),
			saturate(luma + COEF_GU * cu + COEF_GV * cv, CSC_SHIFT),
			saturate(luma + COEF_BU * cu, CSC_SHIFT)};
	endfunction

	task automatic expect_line();
		logic [23:0] even_rgb;
		logic [23:0] odd_rgb;
		for (int j = 0; j < LINE_PAIRS; j++) begin
			even_rgb = pixel_rgb(line_y_even[j], line_u[j], line_v[j]);
			odd_rgb = pixel_rgb(line_y_odd[j], odd_chroma(1'b0, j), odd_chroma(1'b1, j));
			exp_words.push_back(even_rgb[23:8]);
			exp_words.push_back({even_rgb[7:0], odd_rgb[23:16]});
			exp_words.push_back(odd_rgb[15:0]);
			exp_ends.push_back(1'b0);
			exp_ends.push_back(1'b0);
			exp_ends.push_back(j == LINE_PAIRS - 1);
		end
	endtask

	// Output words are sampled away from the rising edge
	always @(negedge CLOCK_50_I) begin
		logic [WORD_W-1:0] exp_word;
		logic exp_end;
		if (resetn && out_valid) begin
			assert (exp_words.size() > 0)
				else stop_on_error("An output word appeared when none was expected");
			if (exp_words.size() > 0) begin
				exp_word = exp_words.pop_front();
				exp_end = exp_ends.pop_front();
				assert (out_word == exp_word)
					else stop_on_error($sformatf("FAIL out_word: got %h expected %h",
						out_word, exp_word));
				assert (out_line_end == exp_end)
					else stop_on_error($sformatf("FAIL out_line_end: got %h expected %h",
						out_line_end, exp_end));
			end
		end
	end

	task automatic send_pair(input int j);
		int busy_len;
		while (busy)
			@(negedge CLOCK_50_I);
		in_valid = 1'b1;
		in_y_even = line_y_even[j];
		in_y_odd = line_y_odd[j];
		in_u = line_u[j];
		in_v = line_v[j];
		@(negedge CLOCK_50_I);
		in_valid = 1'b0;
		// A pair that releases a window keeps execute busy for one pair time
		if (j >= 3 && j < LINE_PAIRS - 1) begin
			busy_len = 0;
			while (busy) begin
				busy_len++;
				@(negedge CLOCK_50_I);
			end
			assert (busy_len == PAIR_CYCLES + 1)
				else stop_on_error($sformatf("FAIL busy: high for %h cycles expected %h",
					busy_len, PAIR_CYCLES + 1));
		end
	endtask

	task automatic drive_line();
		for (int j = 0; j < LINE_PAIRS; j++)
			send_pair(j);
	endtask

	task automatic drain_outputs();
		while (exp_words.size() != 0)
			@(negedge CLOCK_50_I);
		// Room for any stray word to show up
		repeat (PAIR_CYCLES + 4) @(negedge CLOCK_50_I);
	endtask

	task automatic run_single_line();
		expect_line();
		drive_line();
		drain_outputs();
	endtask

	task automatic test_reset_idle();
		repeat (10) begin
			@(negedge CLOCK_50_I);
			assert (!busy && !out_valid)
				else stop_on_error($sformatf(
					"FAIL busy/out_valid after reset: got %h/%h expected 0/0",
					busy, out_valid));
		end
	endtask

	task automatic test_flat_grey();
		for (int k = 0; k < LINE_PAIRS; k++) begin
			line_y_even[k] = 8'd128;
			line_y_odd[k] = 8'd128;
			line_u[k] = 8'd128;
			line_v[k] = 8'd128;
		end
		run_single_line();
	endtask

	task automatic test_chroma_ramp();
		for (int k = 0; k < LINE_PAIRS; k++) begin
			line_y_even[k] = sample_t'(16 + k);
			line_y_odd[k] = sample_t'(200 - k);
			line_u[k] = sample_t'(40 + k);
			line_v[k] = sample_t'(219 - k);
		end
		run_single_line();
	endtask

	task automatic test_clipping();
		for (int k = 0; k < LINE_PAIRS; k++) begin
			line_y_even[k] = 8'd255;
			line_y_odd[k] = 8'd255;
			line_u[k] = 8'd0;
			line_v[k] = 8'd255;
		end
		run_single_line();
		// Dark line with chroma swinging between the extremes
		for (int k = 0; k < LINE_PAIRS; k++) begin
			line_y_even[k] = 8'd0;
			line_y_odd[k] = 8'd0;
			line_u[k] = k[0] ? 8'd255 : 8'd0;
			line_v[k] = k[0] ? 8'd0 : 8'd255;
		end
		run_single_line();
	endtask

	task automatic fill_random_line();
		for (int k = 0; k < LINE_PAIRS; k++) begin
			line_y_even[k] = random_sample();
			line_y_odd[k] = random_sample();
			line_u[k] = random_sample();
			line_v[k] = random_sample();
		end
	endtask

	task automatic test_random_lines();
		fill_random_line();
		expect_line();
		drive_line();
		// Second line follows straight after the flush
		fill_random_line();
		expect_line();
		drive_line();
		drain_outputs();
	endtask

	initial begin
		CLOCK_50_I = 1'b0;
		resetn = 1'b0;
		in_valid = 1'b0;
		in_y_even = '0;
		in_y_odd = '0;
		in_u = '0;
		in_v = '0;
		cycle_count = 0;
		lfsr_state = 32'ha7ce;
		repeat (8) @(negedge CLOCK_50_I);
		resetn = 1'b1;

		test_reset_idle();
		test_flat_grey();
		test_chroma_ramp();
		test_clipping();
		test_random_lines();

		$display("Test passed");
		$finish;
	end

endmodule
